/* hw/pyon_params.svh */
`ifndef PYON_PARAMS_SVH
`define PYON_PARAMS_SVH

// ------------------------------
// game setup
// ------------------------------

// box walk order, bit 0 first, 0 = left and 1 = right
`define PYON_BOX_PATTERN 33'b0_1101_0001_0101_1101_1001_0110_1000_1001

// board oscillator
`define PYON_CLK_HZ 50000000

// both sides start at 32 boxes left
`define PYON_SCORE_TENS 4'd3
`define PYON_SCORE_ONES 4'd2

// ------------------------------
// seven-segment codes, active low
// ------------------------------
`define PYON_SEG_0 7'b100_0000
`define PYON_SEG_1 7'b111_1001
`define PYON_SEG_2 7'b010_0100
`define PYON_SEG_3 7'b011_0000
`define PYON_SEG_4 7'b001_1001
`define PYON_SEG_5 7'b001_0010
`define PYON_SEG_6 7'b000_0010
`define PYON_SEG_7 7'b111_1000
`define PYON_SEG_8 7'b000_0000
`define PYON_SEG_9 7'b001_0000
// out-of-range digits fall back to the zero shape
`define PYON_SEG_BLANK_DEFAULT 7'b100_0000

`endif

/* hw/pyon_pkg.sv */
package pyon_pkg;

  // ------------------------------
  // shared vector types
  // ------------------------------

  // one decimal digit
  typedef logic [3:0] bcd_t;

  // segments g..a, low = lit
  typedef logic [6:0] seg_t;

  // pacer count and period, wide enough for a 50 MHz second
  typedef logic [27:0] div_cnt_t;

  // box walk, bit 0 is the box under the player
  typedef logic [32:0] box_seq_t;

  // ------------------------------
  // opponent speed switch
  // ------------------------------
  typedef enum logic [1:0] {
    SPEED_EASY    = 2'd0,  // two thirds of a second per box
    SPEED_MEDIUM  = 2'd1,  // half a second
    SPEED_HARD    = 2'd2,  // a third of a second
    SPEED_EXTREME = 2'd3   // a fifth of a second
  } speed_t;

endpackage

/* hw/key_judge.sv */
`timescale 1ns/1ps
`include "pyon_params.svh"

module key_judge import pyon_pkg::*; (
  input  logic clk,
  input  logic resetn,
  input  logic run,        // game running
  input  logic key_left,   // active high, already inverted
  input  logic key_right,
  output logic hit         // one-cycle strobe per correct press
);

  // ------------------------------
  // state
  // ------------------------------
  box_seq_t seq;           // remaining boxes, bit 0 current
  logic     left_cur;      // latest key samples
  logic     right_cur;
  logic     left_prev;     // samples one edge older
  logic     right_prev;
  logic     left_rise;
  logic     right_rise;
  logic     match;

  // new press = pressed now, released one sample earlier
  assign left_rise  = left_cur & ~left_prev;
  assign right_rise = right_cur & ~right_prev;

  // box bit 0 picks which key counts
  assign match = seq[0] ? right_rise : left_rise;

  // key sampling
  always_ff @(posedge clk) begin
    if (!resetn) begin
      left_cur   <= 1'b0;  // treat keys as released
      right_cur  <= 1'b0;
      left_prev  <= 1'b0;
      right_prev <= 1'b0;
    end else begin
      left_cur   <= key_left;
      right_cur  <= key_right;
      left_prev  <= left_cur;   // keep older sample
      right_prev <= right_cur;
    end
  end

  // hit strobe and box advance share one edge
  always_ff @(posedge clk) begin
    if (!resetn) begin
      seq <= `PYON_BOX_PATTERN;  // fresh walk every reset
      hit <= 1'b0;
    end else begin
      hit <= match & run;        // no hits while paused
      if (match && run) begin
        seq <= seq >> 1;         // next box moves into bit 0, zero fill
      end
    end
  end

  // ------------------------------
  // checks
  // ------------------------------
  // back-to-back hits only when the next box sits on the other side
  a_hit_single: assert property (
    @(posedge clk) disable iff (!resetn)
      (match && run) |=> !(match && run && (seq[0] == $past(seq[0])))
  );

endmodule

/* hw/tick_pacer.sv */
`timescale 1ns/1ps

module tick_pacer import pyon_pkg::*; (
  input  logic     clk,
  input  logic     resetn,
  input  logic     run,     // count only while running
  input  div_cnt_t period,  // cycles per tick, read at reload
  output logic     tick     // one-cycle strobe
);

  // ------------------------------
  // reloading down-counter
  // ------------------------------
  div_cnt_t count;          // cycles left before next tick
  div_cnt_t reload;

  assign reload = period - div_cnt_t'(1);  // zero counts as a cycle

  // tick lives in the cycle where count sits at zero
  assign tick = run & (count == '0);

  always_ff @(posedge clk) begin
    if (!resetn) begin
      count <= reload;                   // first tick lands period cycles in
    end else if (run) begin
      if (count == '0) begin
        count <= reload;                 // new speed picked up here
      end else begin
        count <= count - div_cnt_t'(1);
      end
    end
    // paused: count holds where it stopped
  end

  // ------------------------------
  // checks
  // ------------------------------
  // no strobe may sneak out of a held count
  a_no_tick_paused: assert property (
    @(posedge clk) disable iff (!resetn)
      !run |-> !tick
  );

endmodule

/* hw/bcd_score.sv */
`timescale 1ns/1ps
`include "pyon_params.svh"

module bcd_score import pyon_pkg::*; (
  input  logic clk,
  input  logic resetn,
  input  logic dec,     // strobe, one box gone
  input  logic freeze,  // game over
  output bcd_t tens,
  output bcd_t ones,
  output logic done     // strobe arrived at 00
);

  logic at_zero;

  assign at_zero = (tens == 4'd0) && (ones == 4'd0);

  // ------------------------------
  // two-digit down-counter
  // ------------------------------
  always_ff @(posedge clk) begin
    if (!resetn) begin
      tens <= `PYON_SCORE_TENS;  // start at 32
      ones <= `PYON_SCORE_ONES;
      done <= 1'b0;
    end else if (dec && !freeze) begin
      if (at_zero) begin
        done <= 1'b1;            // sticky until reset
      end else if (ones == 4'd0) begin
        ones <= 4'd9;            // borrow from tens
        tens <= tens - 4'd1;
      end else begin
        ones <= ones - 4'd1;
      end
    end
    // strobes while frozen are dropped
  end

  // ------------------------------
  // checks
  // ------------------------------
  // borrow path must never leave a non-decimal digit behind
  a_digits_bcd: assert property (
    @(posedge clk) disable iff (!resetn)
      (tens <= 4'd9) && (ones <= 4'd9)
  );

endmodule

/* hw/bcd_timer.sv */
`timescale 1ns/1ps

module bcd_timer import pyon_pkg::*; (
  input  logic clk,
  input  logic resetn,
  input  logic inc,     // one-second strobe
  input  logic freeze,  // game over
  output bcd_t tens,
  output bcd_t ones
);

  logic ones_wrap;
  logic tens_wrap;

  assign ones_wrap = (ones == 4'd9);
  assign tens_wrap = (tens == 4'd9);

  // ------------------------------
  // two-digit up-counter
  // ------------------------------
  always_ff @(posedge clk) begin
    if (!resetn) begin
      tens <= 4'd0;        // game clock starts at 00
      ones <= 4'd0;
    end else if (inc && !freeze) begin
      if (ones_wrap) begin
        ones <= 4'd0;      // carry into tens
        if (tens_wrap) begin
          tens <= 4'd0;    // 99 rolls to 00
        end else begin
          tens <= tens + 4'd1;
        end
      end else begin
        ones <= ones + 4'd1;
      end
    end
    // frozen: hold the final time
  end

  // ------------------------------
  // checks
  // ------------------------------
  // carry chain must keep both digits decimal across wraps
  a_digits_bcd: assert property (
    @(posedge clk) disable iff (!resetn)
      (tens <= 4'd9) && (ones <= 4'd9)
  );

endmodule

/* hw/seg_decoder.sv */
`timescale 1ns/1ps
`include "pyon_params.svh"

module seg_decoder import pyon_pkg::*; (
  input  bcd_t digit,  // 0..9 expected
  output seg_t seg     // active low
);

  // ------------------------------
  // digit lookup
  // ------------------------------
  always_comb begin
    case (digit)
      4'd0:    seg = `PYON_SEG_0;
      4'd1:    seg = `PYON_SEG_1;
      4'd2:    seg = `PYON_SEG_2;
      4'd3:    seg = `PYON_SEG_3;
      4'd4:    seg = `PYON_SEG_4;
      4'd5:    seg = `PYON_SEG_5;
      4'd6:    seg = `PYON_SEG_6;
      4'd7:    seg = `PYON_SEG_7;
      4'd8:    seg = `PYON_SEG_8;
      4'd9:    seg = `PYON_SEG_9;
      default: seg = `PYON_SEG_BLANK_DEFAULT;  // a..f show as 0
    endcase
  end

endmodule

/* hw/pyon_top.sv */
`timescale 1ns/1ps
`include "pyon_params.svh"

module pyon_top import pyon_pkg::*; #(
  parameter int clk_hz = `PYON_CLK_HZ  // cycles per second
) (
  input  logic   clk,
  input  logic   resetn,
  input  logic   run,            // game running switch
  input  logic   key_left_n,     // push keys, low = pressed
  input  logic   key_right_n,
  input  speed_t speed,          // opponent pace
  output seg_t   hex_timer_lo,
  output seg_t   hex_timer_hi,
  output seg_t   hex_pc_lo,
  output seg_t   hex_pc_hi,
  output seg_t   hex_player_lo,
  output seg_t   hex_player_hi,
  output logic   game_over       // either side finished
);

  // ------------------------------
  // pacer periods, rounded down
  // ------------------------------
  localparam div_cnt_t PERIOD_EASY    = div_cnt_t'((clk_hz * 2) / 3);
  localparam div_cnt_t PERIOD_MEDIUM  = div_cnt_t'(clk_hz / 2);
  localparam div_cnt_t PERIOD_HARD    = div_cnt_t'(clk_hz / 3);
  localparam div_cnt_t PERIOD_EXTREME = div_cnt_t'(clk_hz / 5);
  localparam div_cnt_t PERIOD_SECOND  = div_cnt_t'(clk_hz);

  logic     key_left;
  logic     key_right;
  logic     hit;                 // correct press strobe
  logic     pc_tick;             // opponent step strobe
  logic     sec_tick;            // one-second strobe
  div_cnt_t pc_period;
  logic     player_done;
  logic     pc_done;
  bcd_t     timer_tens;
  bcd_t     timer_ones;
  bcd_t     pc_tens;
  bcd_t     pc_ones;
  bcd_t     player_tens;
  bcd_t     player_ones;

  assign key_left  = ~key_left_n;   // keys idle high
  assign key_right = ~key_right_n;

  // opponent pace follows the switch live
  always_comb begin
    case (speed)
      SPEED_EASY:    pc_period = PERIOD_EASY;
      SPEED_MEDIUM:  pc_period = PERIOD_MEDIUM;
      SPEED_HARD:    pc_period = PERIOD_HARD;
      SPEED_EXTREME: pc_period = PERIOD_EXTREME;
      default:       pc_period = PERIOD_EASY;
    endcase
  end

  // sticky end of game, freezes all three counters
  always_ff @(posedge clk) begin
    if (!resetn) begin
      game_over <= 1'b0;
    end else begin
      game_over <= game_over | player_done | pc_done;
    end
  end

  // ------------------------------
  // player side
  // ------------------------------
  key_judge u_key (
    .clk       (clk),
    .resetn    (resetn),
    .run       (run),
    .key_left  (key_left),
    .key_right (key_right),
    .hit       (hit)
  );

  bcd_score u_player_score (
    .clk    (clk),
    .resetn (resetn),
    .dec    (hit),
    .freeze (game_over),
    .tens   (player_tens),
    .ones   (player_ones),
    .done   (player_done)
  );

  // ------------------------------
  // opponent side
  // ------------------------------
  tick_pacer u_pc_pace (
    .clk    (clk),
    .resetn (resetn),
    .run    (run),
    .period (pc_period),
    .tick   (pc_tick)
  );

  bcd_score u_pc_score (
    .clk    (clk),
    .resetn (resetn),
    .dec    (pc_tick),
    .freeze (game_over),
    .tens   (pc_tens),
    .ones   (pc_ones),
    .done   (pc_done)
  );

  // ------------------------------
  // game clock
  // ------------------------------
  tick_pacer u_sec_pace (
    .clk    (clk),
    .resetn (resetn),
    .run    (run),
    .period (PERIOD_SECOND),
    .tick   (sec_tick)
  );

  bcd_timer u_timer (
    .clk    (clk),
    .resetn (resetn),
    .inc    (sec_tick),
    .freeze (game_over),
    .tens   (timer_tens),
    .ones   (timer_ones)
  );

  // ------------------------------
  // displays
  // ------------------------------
  seg_decoder u_seg_timer_lo  (.digit(timer_ones),  .seg(hex_timer_lo));
  seg_decoder u_seg_timer_hi  (.digit(timer_tens),  .seg(hex_timer_hi));
  seg_decoder u_seg_pc_lo     (.digit(pc_ones),     .seg(hex_pc_lo));
  seg_decoder u_seg_pc_hi     (.digit(pc_tens),     .seg(hex_pc_hi));
  seg_decoder u_seg_player_lo (.digit(player_ones), .seg(hex_player_lo));
  seg_decoder u_seg_player_hi (.digit(player_tens), .seg(hex_player_hi));

endmodule

/* sim/tb_pyon.sv */
`timescale 1ns/1ps
`include "pyon_params.svh"

module tb_pyon import pyon_pkg::*; ();

  // ------------------------------
  // run lengths
  // ------------------------------
  localparam int CLK_HZ       = 60;        // short second
  localparam int RESET_CYCLES = 5;
  localparam int START_SCORE  = 32;
  localparam int RAND_CYCLES  = 160;
  localparam int PACE_TICKS   = 10;        // opponent steps per speed
  localparam int WRAP_CYCLES  = 101 * CLK_HZ;
  localparam int RUN_CYCLES   = 60;
  localparam int PAUSE_CYCLES = 120;
  localparam int TAIL_CYCLES  = 200;
  localparam int TOTAL_CYCLES = 9 * RESET_CYCLES + 4 + RAND_CYCLES
    + PACE_TICKS * ((CLK_HZ * 2) / 3 + CLK_HZ / 2 + CLK_HZ / 3 + CLK_HZ / 5)
    + WRAP_CYCLES + 2 * RUN_CYCLES + PAUSE_CYCLES + 33 * 4 + TAIL_CYCLES;
  localparam int WATCHDOG_CYCLES = TOTAL_CYCLES + 500;
  localparam logic [31:0] RAND_SEED = 32'h2d3f_ed1e;

  logic   clk;
  logic   resetn;
  logic   run;
  logic   key_left_n;
  logic   key_right_n;
  speed_t speed;
  seg_t   hex_timer_lo;
  seg_t   hex_timer_hi;
  seg_t   hex_pc_lo;
  seg_t   hex_pc_hi;
  seg_t   hex_player_lo;
  seg_t   hex_player_hi;
  logic   game_over;

  // reference model state
  box_seq_t m_seq;                         // boxes left, bit 0 current
  logic     m_lcur, m_rcur, m_lprev, m_rprev;
  logic     m_hit;
  int       m_pc_cnt, m_sec_cnt;           // pacer countdowns
  int       m_player, m_pc, m_timer;       // plain integer values
  logic     m_player_done, m_pc_done, m_over;
  logic     pc_blocked;                    // opponent strobe held off

  int       n_checks, n_errors, test_start_errors;
  logic [41:0] snap;

  pyon_top #(.clk_hz(CLK_HZ)) u_dut (
    .clk(clk), .resetn(resetn), .run(run),
    .key_left_n(key_left_n), .key_right_n(key_right_n), .speed(speed),
    .hex_timer_lo(hex_timer_lo), .hex_timer_hi(hex_timer_hi),
    .hex_pc_lo(hex_pc_lo), .hex_pc_hi(hex_pc_hi),
    .hex_player_lo(hex_player_lo), .hex_player_hi(hex_player_hi),
    .game_over(game_over)
  );

  always #10 clk = ~clk;                   // 20 ns period

  // ------------------------------
  // model helpers
  // ------------------------------
  function automatic seg_t seg_of(int d);
    case (d)
      0: return 7'h40;
      1: return 7'h79;
      2: return 7'h24;
      3: return 7'h30;
      4: return 7'h19;
      5: return 7'h12;
      6: return 7'h02;
      7: return 7'h78;
      8: return 7'h00;
      default: return 7'h10;               // nine
    endcase
  endfunction

  // opponent pace as a fraction of a second, rounded down
  function automatic int period_for(speed_t s);
    case (s)
      SPEED_EASY:   return (CLK_HZ * 2) / 3;
      SPEED_MEDIUM: return CLK_HZ / 2;
      SPEED_HARD:   return CLK_HZ / 3;
      default:      return CLK_HZ / 5;
    endcase
  endfunction

  // one clock edge of the game rules, using the inputs held at the edge
  task automatic model_edge();
    logic pc_tick, sec_tick, l_new, r_new, match, over_next;
    if (!resetn) begin
      m_seq = `PYON_BOX_PATTERN;
      {m_lcur, m_rcur, m_lprev, m_rprev, m_hit} = '0;
      m_pc_cnt = period_for(speed) - 1;
      m_sec_cnt = CLK_HZ - 1;
      m_player = START_SCORE;
      m_pc = START_SCORE;
      m_timer = 0;
      {m_player_done, m_pc_done, m_over} = '0;
    end else begin
      pc_tick  = run && (m_pc_cnt == 0) && !pc_blocked;
      sec_tick = run && (m_sec_cnt == 0);
      over_next = m_over | m_player_done | m_pc_done;
      if (m_hit && !m_over) begin
        if (m_player == 0) m_player_done = 1'b1;  // strobe at 00 ends it
        else m_player--;
      end
      if (pc_tick && !m_over) begin
        if (m_pc == 0) m_pc_done = 1'b1;
        else m_pc--;
      end
      if (sec_tick && !m_over) m_timer = (m_timer + 1) % 100;
      m_over = over_next;
      l_new = m_lcur && !m_lprev;          // fresh press only
      r_new = m_rcur && !m_rprev;
      match = m_seq[0] ? r_new : l_new;
      m_hit = match && run;
      if (match && run) m_seq = m_seq >> 1;
      m_lprev = m_lcur;
      m_rprev = m_rcur;
      m_lcur = !key_left_n;
      m_rcur = !key_right_n;
      if (run) begin
        m_pc_cnt  = (m_pc_cnt == 0) ? period_for(speed) - 1 : m_pc_cnt - 1;
        m_sec_cnt = (m_sec_cnt == 0) ? CLK_HZ - 1 : m_sec_cnt - 1;
      end
    end
  endtask

  // ------------------------------
  // checks
  // ------------------------------
  task automatic check_val(string name, logic [6:0] got, logic [6:0] exp);
    n_checks++;
    assert (got === exp) else begin
      $display("MISMATCH %s at %0t ns: expected %h, got %h", name, $time, exp, got);
      n_errors++;
    end
  endtask

  task automatic compare_all();
    check_val("hex_timer_lo", hex_timer_lo, seg_of(m_timer % 10));
    check_val("hex_timer_hi", hex_timer_hi, seg_of(m_timer / 10));
    check_val("hex_pc_lo", hex_pc_lo, seg_of(m_pc % 10));
    check_val("hex_pc_hi", hex_pc_hi, seg_of(m_pc / 10));
    check_val("hex_player_lo", hex_player_lo, seg_of(m_player % 10));
    check_val("hex_player_hi", hex_player_hi, seg_of(m_player / 10));
    check_val("game_over", {6'b0, game_over}, {6'b0, m_over});
  endtask

  // edge, model update, compare, then back at the drive point
  task automatic step();
    @(posedge clk);
    model_edge();
    #1;
    compare_all();
    #1;
  endtask

  task automatic do_reset(speed_t s);
    resetn = 1'b0;
    run = 1'b0;
    key_left_n = 1'b1;                     // keys idle high
    key_right_n = 1'b1;
    speed = s;
    repeat (RESET_CYCLES) step();
    resetn = 1'b1;
  endtask

  task automatic random_keys();
    int pick;
    if ($urandom % 4 == 0) begin
      pick = $urandom % 4;                 // none, left, right, both
      key_left_n  = !(pick == 1 || pick == 3);
      key_right_n = !(pick == 2 || pick == 3);
    end
  endtask

  task automatic end_test(int num, string name);
    $display("test %0d %s: %0d mismatches", num, name, n_errors - test_start_errors);
    test_start_errors = n_errors;
  endtask

  // ------------------------------
  // test sequence
  // ------------------------------
  initial begin
    void'($urandom(RAND_SEED));
    clk = 1'b0;
    {resetn, run, key_left_n, key_right_n} = 4'b0011;
    speed = SPEED_EASY;
    pc_blocked = 1'b0;
    {n_checks, n_errors, test_start_errors} = '0;

    do_reset(SPEED_EASY);                  // 1: reset values
    repeat (4) step();
    end_test(1, "reset_values");

    do_reset(SPEED_EASY);                  // 2: random keys
    run = 1'b1;
    repeat (RAND_CYCLES) begin
      random_keys();
      if ($urandom % 32 == 0) speed = speed_t'($urandom % 4);
      step();
    end
    end_test(2, "random_keys");

    for (int s = 0; s < 4; s++) begin      // 3: opponent pace per speed
      do_reset(speed_t'(s));
      run = 1'b1;
      repeat (PACE_TICKS * period_for(speed_t'(s))) step();
      check_val("hex_pc_hi", hex_pc_hi, seg_of((START_SCORE - PACE_TICKS) / 10));
      check_val("hex_pc_lo", hex_pc_lo, seg_of((START_SCORE - PACE_TICKS) % 10));
    end
    end_test(3, "opponent_pace");

    do_reset(SPEED_EASY);                  // 4: timer wrap
    force u_dut.pc_tick = 1'b0;            // keep the opponent alive past 99 s
    pc_blocked = 1'b1;
    run = 1'b1;
    repeat (WRAP_CYCLES) step();
    check_val("hex_timer_hi", hex_timer_hi, seg_of(0));
    check_val("hex_timer_lo", hex_timer_lo, seg_of(1));
    release u_dut.pc_tick;
    pc_blocked = 1'b0;
    end_test(4, "timer_wrap");

    do_reset(SPEED_HARD);                  // 5: pause holds everything
    run = 1'b1;
    repeat (RUN_CYCLES) begin
      random_keys();
      step();
    end
    run = 1'b0;
    step();                                // last registered hit lands here
    snap = {hex_timer_lo, hex_timer_hi, hex_pc_lo, hex_pc_hi, hex_player_lo, hex_player_hi};
    repeat (PAUSE_CYCLES - 1) begin
      random_keys();
      step();
    end
    n_checks++;
    assert (snap === {hex_timer_lo, hex_timer_hi, hex_pc_lo, hex_pc_hi,
                      hex_player_lo, hex_player_hi}) else begin
      $display("MISMATCH displays after pause: expected %h, got %h", snap,
               {hex_timer_lo, hex_timer_hi, hex_pc_lo, hex_pc_hi,
                hex_player_lo, hex_player_hi});
      n_errors++;
    end
    run = 1'b1;
    repeat (RUN_CYCLES) begin
      random_keys();
      step();
    end
    end_test(5, "pause_hold");

    do_reset(SPEED_EASY);                  // 6: full pattern ends the game
    run = 1'b1;
    repeat (33) begin
      key_left_n  = m_seq[0];              // press the key under the player
      key_right_n = !m_seq[0];
      repeat (2) step();
      key_left_n  = 1'b1;
      key_right_n = 1'b1;
      repeat (2) step();
    end
    check_val("game_over", {6'b0, game_over}, 7'h01);
    repeat (TAIL_CYCLES) begin
      random_keys();
      if ($urandom % 16 == 0) speed = speed_t'($urandom % 4);
      step();
    end
    end_test(6, "full_pattern");

    $display("checks %0d, mismatches %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  // ------------------------------
  // watchdog
  // ------------------------------
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout: run still going after %0d cycles", WATCHDOG_CYCLES);
    $display("Regression failed");
    $finish;
  end

endmodule

/* flist.f */
+incdir+hw
hw/pyon_pkg.sv
hw/key_judge.sv
hw/tick_pacer.sv
hw/bcd_score.sv
hw/bcd_timer.sv
hw/seg_decoder.sv
hw/pyon_top.sv
sim/tb_pyon.sv
